// File: tb.f
src/rv32_pkg.sv
src/fetch_unit.sv
src/decode_unit.sv
src/alu_execute.sv
src/mul_unit.sv
src/commit_unit.sv
src/core_top.sv
test/tb_imem.sv
test/tb_core.sv

// File: Makefile
# Verilator flow for the RV32 core slice testbench

SIM_LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module tb_core -f tb.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_core -f tb.f
	-./obj_dir/Vtb_core > $(SIM_LOG) 2>&1
	cat $(SIM_LOG)
	! grep -q "Simulation FAILED" $(SIM_LOG)
	grep -q "Simulation PASSED" $(SIM_LOG)

clean:
	rm -rf obj_dir $(SIM_LOG)

// File: test/tb_core.sv
`timescale 1ns/1ns

module tb_core;
    import rv32_pkg::*;

    localparam int mem_depth  = 128;
    localparam int n_tests    = 6;
    localparam int t_lui_addi = 0;
    localparam int t_alu      = 1;
    localparam int t_fwd      = 2;
    localparam int t_mul      = 3;
    localparam int t_jal      = 4;
    localparam int t_x0       = 5;

    string test_names [0:n_tests-1] = '{"lui_addi", "alu_ops", "forwarding", "mul", "jal",
                                        "x0_noop"};

    logic            clk;
    logic            rst;
    logic            imem_req;
    logic [31:0]     imem_addr;
    logic            imem_ack;
    logic [31:0]     imem_rdata;
    logic            commit_valid;
    commit_t         commit;

    // program image and its per-word tags
    logic [31:0]     prog [0:mem_depth-1];
    int              prog_test [0:mem_depth-1];
    logic            prog_shadow [0:mem_depth-1];
    int              n_prog;

    // golden model state and expected retirement stream
    logic [31:0]     gold_regs [0:31];
    logic [31:0]     exp_pc [0:mem_depth-1];
    logic [31:0]     exp_next_pc [0:mem_depth-1];
    logic [31:0]     exp_inst [0:mem_depth-1];
    logic [4:0]      exp_rd [0:mem_depth-1];
    logic [31:0]     exp_wdata [0:mem_depth-1];
    int              exp_test [0:mem_depth-1];
    int              test_last [0:n_tests-1];
    int              test_err [0:n_tests-1];
    int              n_exp;

    int              ret_idx = 0;
    int              cur_test;
    logic            checking;
    logic            done = 1'b0;
    logic            seen_req = 1'b0;
    int              errors = 0;
    int              cycles = 0;
    int              timeout_limit;

    core_top dut (.*);

    tb_imem #(.depth(mem_depth)) imem (
        .clk   (clk),
        .rst   (rst),
        .req   (imem_req),
        .addr  (imem_addr),
        .ack   (imem_ack),
        .rdata (imem_rdata)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // instruction encoders
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                          input int rd, input int rs1, input int rs2);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), opc_op};
    endfunction

    function automatic logic [31:0] enc_i(input logic [2:0] f3, input int rd, input int rs1,
                                          input logic [11:0] imm);
        return {imm, 5'(rs1), f3, 5'(rd), opc_op_imm};
    endfunction

    function automatic logic [31:0] enc_lui(input int rd, input logic [19:0] imm);
        return {imm, 5'(rd), opc_lui};
    endfunction

    function automatic logic [31:0] enc_jal(input int rd, input int offset);
        logic [20:0] o;
        o = 21'(offset);
        return {o[20], o[10:1], o[11], o[19:12], 5'(rd), opc_jal};
    endfunction

    // sources only among x1..x8, written first
    function automatic int rand_reg();
        return 1 + int'($urandom_range(7, 0));
    endfunction

    task automatic put(input logic [31:0] word, input int test, input logic shadow);
        prog[n_prog]        = word;
        prog_test[n_prog]   = test;
        prog_shadow[n_prog] = shadow;
        n_prog++;
    endtask

    task automatic build_program();
        logic [31:0] r;
        logic [11:0] imm;
        n_prog = 0;
        for (int i = 1; i <= 8; i++)
        begin
            r = $urandom;
            put(enc_lui(i, r[31:12]), t_lui_addi, 1'b0);
            put(enc_i(3'd0, i, i, r[11:0]), t_lui_addi, 1'b0);
        end
        // register forms, then sub and sra
        for (int f = 0; f < 8; f++)
            put(enc_r(7'h00, 3'(f), 9 + f, rand_reg(), rand_reg()), t_alu, 1'b0);
        put(enc_r(7'h20, 3'd0, 17, rand_reg(), rand_reg()), t_alu, 1'b0);
        put(enc_r(7'h20, 3'd5, 18, rand_reg(), rand_reg()), t_alu, 1'b0);
        // immediate forms, shifts carry funct7 in imm[11:5]
        for (int f = 0; f < 8; f++)
        begin
            r = $urandom;
            if (f == 1)
                imm = {7'h00, r[4:0]};
            else if (f == 5)
                imm = {r[5] ? 7'h20 : 7'h00, r[4:0]};
            else
                imm = r[11:0];
            put(enc_i(3'(f), 19 + f, rand_reg(), imm), t_alu, 1'b0);
        end
        // chain where each word needs the one before it
        r = $urandom;
        put(enc_r(7'h00, 3'd0, 10, 1, 2), t_fwd, 1'b0);
        put(enc_r(7'h20, 3'd0, 11, 10, 3), t_fwd, 1'b0);
        put(enc_r(7'h00, 3'd4, 12, 11, 10), t_fwd, 1'b0);
        put(enc_i(3'd0, 12, 12, r[11:0]), t_fwd, 1'b0);
        put(enc_r(7'h00, 3'd6, 13, 12, 12), t_fwd, 1'b0);
        put(enc_i(3'd5, 13, 13, {7'h20, 5'd3}), t_fwd, 1'b0);
        // consumer right behind a multiply, then multiply chains
        put(enc_r(7'h01, 3'd0, 14, 1, 2), t_mul, 1'b0);
        put(enc_r(7'h00, 3'd0, 15, 14, 3), t_mul, 1'b0);
        put(enc_r(7'h01, 3'd0, 16, 14, 15), t_mul, 1'b0);
        put(enc_r(7'h01, 3'd0, 20, 16, 16), t_mul, 1'b0);
        put(enc_r(7'h01, 3'd0, 21, 5, 0), t_mul, 1'b0);
        // jal over two shadow words that would change x5 and x6
        put(enc_jal(5, 12), t_jal, 1'b0);
        put(enc_i(3'd0, 5, 5, 12'd1), t_jal, 1'b1);
        put(enc_lui(6, 20'hdead0), t_jal, 1'b1);
        put(enc_r(7'h00, 3'd0, 22, 5, 1), t_jal, 1'b0);
        // x0 writes, an unknown opcode and an unsupported divide
        r = $urandom;
        put(enc_i(3'd0, 0, 1, r[11:0]), t_x0, 1'b0);
        put(enc_r(7'h00, 3'd0, 23, 0, 2), t_x0, 1'b0);
        put(enc_lui(0, r[31:12]), t_x0, 1'b0);
        put(enc_r(7'h00, 3'd6, 24, 0, 0), t_x0, 1'b0);
        put({r[31:7], 7'h7f}, t_x0, 1'b0);
        put(enc_r(7'h01, 3'd4, 25, 1, 2), t_x0, 1'b0);
        put(enc_i(3'd0, 26, 0, 12'h7ff), t_x0, 1'b0);
        // words past the program decode as no-ops
        for (int a = 0; a < mem_depth; a++)
        begin
            if (a >= n_prog)
            begin
                prog[a]        = {25'(a), 7'h00};
                prog_shadow[a] = 1'b0;
            end
            imem.mem[a] = prog[a];
        end
    endtask

    // instruction-set model of one word, straight from the ISA rules
    task automatic iss_exec(input logic [31:0] pc, input logic [31:0] inst,
                            output logic [31:0] npc, output logic [4:0] rd,
                            output logic [31:0] wd);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] res;
        logic [6:0]  f7;
        logic [2:0]  f3;
        logic        legal;
        a     = gold_regs[inst[19:15]];
        b     = gold_regs[inst[24:20]];
        f7    = inst[31:25];
        f3    = inst[14:12];
        imm   = {{20{inst[31]}}, inst[31:20]};
        npc   = pc + 32'd4;
        legal = 1'b1;
        res   = '0;
        case (inst[6:0])
            opc_op:
                case ({f7, f3})
                    {7'h00, 3'd0}: res = a + b;
                    {7'h20, 3'd0}: res = a - b;
                    {7'h00, 3'd1}: res = a << b[4:0];
                    {7'h00, 3'd2}: res = {31'b0, $signed(a) < $signed(b)};
                    {7'h00, 3'd3}: res = {31'b0, a < b};
                    {7'h00, 3'd4}: res = a ^ b;
                    {7'h00, 3'd5}: res = a >> b[4:0];
                    {7'h20, 3'd5}: res = $unsigned($signed(a) >>> b[4:0]);
                    {7'h00, 3'd6}: res = a | b;
                    {7'h00, 3'd7}: res = a & b;
                    {7'h01, 3'd0}: res = a * b;
                    default:       legal = 1'b0;
                endcase
            opc_op_imm:
                case (f3)
                    3'd0: res = a + imm;
                    3'd2: res = {31'b0, $signed(a) < $signed(imm)};
                    3'd3: res = {31'b0, a < imm};
                    3'd4: res = a ^ imm;
                    3'd6: res = a | imm;
                    3'd7: res = a & imm;
                    3'd1:
                        if (f7 == 7'h00)
                            res = a << inst[24:20];
                        else
                            legal = 1'b0;
                    default:
                        if (f7 == 7'h00)
                            res = a >> inst[24:20];
                        else if (f7 == 7'h20)
                            res = $unsigned($signed(a) >>> inst[24:20]);
                        else
                            legal = 1'b0;
                endcase
            opc_lui:
                res = {inst[31:12], 12'h000};
            opc_jal:
            begin
                res = pc + 32'd4;
                npc = pc + {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default:
                legal = 1'b0;
        endcase
        rd = legal ? inst[11:7] : 5'd0;
        wd = (legal && rd != 5'd0) ? res : '0;
        if (rd != 5'd0)
            gold_regs[rd] = res;
    endtask

    task automatic run_golden();
        logic [31:0] pc;
        logic [31:0] npc;
        logic [4:0]  rd;
        logic [31:0] wd;
        for (int i = 0; i < 32; i++)
            gold_regs[i] = '0;
        for (int t = 0; t < n_tests; t++)
        begin
            test_last[t] = -1;
            test_err[t]  = 0;
        end
        n_exp = 0;
        pc    = '0;
        while (pc < 32'(n_prog * 4))
        begin
            iss_exec(pc, prog[pc[8:2]], npc, rd, wd);
            exp_pc[n_exp]      = pc;
            exp_next_pc[n_exp] = npc;
            exp_inst[n_exp]    = prog[pc[8:2]];
            exp_rd[n_exp]      = rd;
            exp_wdata[n_exp]   = wd;
            exp_test[n_exp]    = prog_test[pc[8:2]];
            test_last[prog_test[pc[8:2]]] = n_exp;
            n_exp++;
            pc = npc;
        end
    endtask

    task automatic count_error();
        errors++;
        test_err[cur_test]++;
    endtask

    assign cur_test = exp_test[ret_idx];
    // commit packets still covered by the expected stream
    assign checking = commit_valid && ret_idx < n_exp;

    always @(posedge clk)
    begin
        if (imem_req)
            seen_req <= 1'b1;
        if (!rst && checking)
        begin
            ret_idx <= ret_idx + 1;
            if (ret_idx == test_last[cur_test])
                $display("test %s finished, %0d errors", test_names[cur_test],
                         test_err[cur_test]);
            if (ret_idx == n_exp - 1)
                done <= 1'b1;
        end
    end

    // checks sampled mid-cycle, away from the drive edge
    assert property (@(negedge clk) rst |-> !imem_req && !commit_valid)
        else
        begin
            $display("imem_req or commit_valid high while rst is high");
            errors++;
        end
    assert property (@(negedge clk) disable iff (rst) imem_req && !seen_req |-> imem_addr == 0)
        else
        begin
            $display("mismatch reset_fetch addr: expected %h, actual %h", 32'h0, imem_addr);
            errors++;
        end
    assert property (@(negedge clk) disable iff (rst) $rose(imem_req) |-> !$past(imem_ack))
        else
        begin
            $display("imem_req was raised while imem_ack was still high");
            errors++;
        end
    assert property (@(negedge clk) disable iff (rst)
        imem_req && $past(imem_req) |-> $stable(imem_addr))
        else
        begin
            $display("imem_addr changed while imem_req was high");
            errors++;
        end
    assert property (@(negedge clk) disable iff (rst) checking |-> commit.order == 64'(ret_idx))
        else
        begin
            $display("mismatch %s order: expected %0d, actual %0d", test_names[cur_test],
                     ret_idx, commit.order);
            count_error();
        end
    assert property (@(negedge clk) disable iff (rst) checking |-> commit.pc == exp_pc[ret_idx])
        else
        begin
            $display("mismatch %s pc: expected %h, actual %h", test_names[cur_test],
                     exp_pc[ret_idx], commit.pc);
            count_error();
        end
    assert property (@(negedge clk) disable iff (rst)
        checking |-> commit.next_pc == exp_next_pc[ret_idx])
        else
        begin
            $display("mismatch %s next_pc: expected %h, actual %h", test_names[cur_test],
                     exp_next_pc[ret_idx], commit.next_pc);
            count_error();
        end
    assert property (@(negedge clk) disable iff (rst)
        checking |-> commit.inst == exp_inst[ret_idx])
        else
        begin
            $display("mismatch %s inst: expected %h, actual %h", test_names[cur_test],
                     exp_inst[ret_idx], commit.inst);
            count_error();
        end
    assert property (@(negedge clk) disable iff (rst) checking |-> commit.rd == exp_rd[ret_idx])
        else
        begin
            $display("mismatch %s rd: expected %0d, actual %0d", test_names[cur_test],
                     exp_rd[ret_idx], commit.rd);
            count_error();
        end
    assert property (@(negedge clk) disable iff (rst)
        checking |-> commit.rd_wdata == exp_wdata[ret_idx])
        else
        begin
            $display("mismatch %s rd_wdata: expected %h, actual %h", test_names[cur_test],
                     exp_wdata[ret_idx], commit.rd_wdata);
            count_error();
        end
    assert property (@(negedge clk) disable iff (rst) checking |-> !prog_shadow[commit.pc[8:2]])
        else
        begin
            $display("shadow word at %h retired after a jal", commit.pc);
            count_error();
        end

    initial
    begin
        void'($urandom(32'h9147_7144));
        rst  = 1'b1;
        build_program();
        run_golden();
        // worst case is every instruction waiting out a multiply plus a fetch
        timeout_limit = n_exp * (mul_cycles + 8);
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        while (!done && cycles < timeout_limit)
        begin
            @(posedge clk);
            cycles++;
        end
        if (!done)
            $display("timeout: %0d of %0d instructions retired in %0d cycles", ret_idx, n_exp,
                     cycles);
        $display("tests %0d, instructions %0d, errors %0d", n_tests, ret_idx, errors);
        if (done && errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

// File: test/tb_imem.sv
`timescale 1ns/1ns

module tb_imem #(
    parameter int depth = 128
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        req,
    input  logic [31:0] addr,
    output logic        ack,
    output logic [31:0] rdata
);
    // program image, written by the testbench at time 0
    logic [31:0] mem [0:depth-1];
    // cycles still to wait before ack
    int unsigned wait_cnt;

    initial
    begin
        ack      = 1'b0;
        rdata    = '0;
        wait_cnt = 0;
    end

    always @(posedge clk)
    begin
        if (rst)
        begin
            ack      <= 1'b0;
            wait_cnt <= $urandom_range(3, 0);
        end
        else if (!ack)
        begin
            // phase two once the latency has run out
            if (req && wait_cnt == 0)
            begin
                ack   <= 1'b1;
                rdata <= mem[addr[$clog2(depth)+1:2]];
            end
            else if (req)
                wait_cnt <= wait_cnt - 1;
        end
        else if (!req)
        begin
            // phase four, draw the latency of the next fetch
            ack      <= 1'b0;
            wait_cnt <= $urandom_range(3, 0);
        end
    end

endmodule

// File: src/core_top.sv
`timescale 1ns/1ns

module core_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      imem_ack,
    input  logic [rv32_pkg::xlen-1:0] imem_rdata,
    output logic                      imem_req,
    output logic [rv32_pkg::xlen-1:0] imem_addr,
    output logic                      commit_valid,
    output rv32_pkg::commit_t         commit
);
    import rv32_pkg::*;

    // fetch to decode
    logic            fetch_valid;
    logic [xlen-1:0] fetch_pc;
    logic [31:0]     fetch_inst;
    logic            decode_ready;
    logic            redirect;
    logic [xlen-1:0] redirect_pc;

    // register file read ports
    reg_addr_t       rs1_addr;
    reg_addr_t       rs2_addr;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;

    // issue register and execute results
    issue_t          issue;
    logic            issue_valid;
    result_t         alu_res;
    logic            alu_valid;
    result_t         mul_res;
    logic            mul_done;
    logic            mul_busy;

    fetch_unit u_fetch (.*);

    decode_unit u_decode (.*);

    alu_execute u_alu (.*);

    mul_unit u_mul (.*);

    commit_unit u_commit (.*);

endmodule

// File: src/commit_unit.sv
`timescale 1ns/1ns

module commit_unit (
    input  logic                      clk,
    input  logic                      rst,
    input  rv32_pkg::result_t         alu_res,
    input  logic                      alu_valid,
    input  rv32_pkg::result_t         mul_res,
    input  logic                      mul_done,
    input  rv32_pkg::reg_addr_t       rs1_addr,
    input  rv32_pkg::reg_addr_t       rs2_addr,
    output logic [rv32_pkg::xlen-1:0] rs1_data,
    output logic [rv32_pkg::xlen-1:0] rs2_data,
    output logic                      commit_valid,
    output rv32_pkg::commit_t         commit
);
    import rv32_pkg::*;

    // x1..x31, x0 is hardwired
    logic [xlen-1:0] regs [1:31];
    logic [63:0]     order_cnt;
    result_t         res;
    logic            retire;
    logic            wr_en;

    assign retire = alu_valid || mul_done;
    assign res    = mul_done ? mul_res : alu_res;
    assign wr_en  = retire && res.rd_we && res.rd != '0;

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            commit_valid <= 1'b0;
            order_cnt    <= '0;
        end
        else
        begin
            commit_valid <= retire;
            if (retire)
                order_cnt <= order_cnt + 64'd1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_en)
            regs[res.rd] <= res.value;
        if (retire)
        begin
            commit.order    <= order_cnt;
            commit.pc       <= res.pc;
            // jal target recomputed from the instruction word
            commit.next_pc  <= (res.inst[6:0] == opc_jal) ? res.pc + jal_offset(res.inst)
                                                           : res.pc + 32'd4;
            commit.inst     <= res.inst;
            commit.rd       <= res.rd_we ? res.rd : '0;
            commit.rd_wdata <= wr_en ? res.value : '0;
        end
    end

    // one retirement per cycle, relies on decode stalling behind mul
    assert property (@(posedge clk) disable iff (rst) !(alu_valid && mul_done))
        else $error("alu and mul results retiring together");

endmodule

// File: src/mul_unit.sv
`timescale 1ns/1ns

module mul_unit (
    input  logic              clk,
    input  logic              rst,
    input  rv32_pkg::issue_t  issue,
    input  logic              issue_valid,
    output logic              mul_busy,
    output rv32_pkg::result_t mul_res,
    output logic              mul_done
);
    import rv32_pkg::*;

    logic                 start;
    logic [mul_cnt_w-1:0] count;
    // low half accumulator, shifted multiplicand, remaining multiplier bits
    logic [xlen-1:0]      acc;
    logic [xlen-1:0]      mcand;
    logic [xlen-1:0]      mplier;
    logic [xlen-1:0]      pc_q;
    logic [31:0]          inst_q;
    reg_addr_t            rd_q;
    logic                 rd_we_q;

    assign start    = issue_valid && issue.unit == unit_mul;
    assign mul_done = mul_busy && count == mul_cnt_w'(mul_cycles);
    assign mul_res  = '{pc: pc_q, inst: inst_q, rd: rd_q, rd_we: rd_we_q, value: acc};

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            mul_busy <= 1'b0;
            count    <= '0;
        end
        else if (start)
        begin
            mul_busy <= 1'b1;
            count    <= mul_cnt_w'(1);
        end
        else if (mul_done)
            mul_busy <= 1'b0;
        else if (mul_busy)
            count <= count + 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (start)
        begin
            // first step taken on the accept edge
            acc     <= issue.operand_b[0] ? issue.operand_a : '0;
            mcand   <= issue.operand_a << 1;
            mplier  <= issue.operand_b >> 1;
            pc_q    <= issue.pc;
            inst_q  <= issue.inst;
            rd_q    <= issue.rd;
            rd_we_q <= issue.rd_we;
        end
        else if (mul_busy && !mul_done)
        begin
            if (mplier[0])
                acc <= acc + mcand;
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    // decode must hold further multiplies until this one drains
    assert property (@(posedge clk) disable iff (rst) start |-> !mul_busy)
        else $error("multiply issued while mul_busy");

endmodule

// File: src/alu_execute.sv
`timescale 1ns/1ns

module alu_execute (
    input  rv32_pkg::issue_t  issue,
    input  logic              issue_valid,
    output rv32_pkg::result_t alu_res,
    output logic              alu_valid
);
    import rv32_pkg::*;

    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [4:0]      shamt;
    logic [xlen-1:0] value;

    assign a     = issue.operand_a;
    assign b     = issue.operand_b;
    assign shamt = b[4:0];

    always_comb
    begin
        case (issue.alu_op)
            alu_add:    value = a + b;
            alu_sub:    value = a - b;
            alu_sll:    value = a << shamt;
            alu_slt:    value = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            alu_sltu:   value = {{(xlen-1){1'b0}}, a < b};
            alu_xor:    value = a ^ b;
            alu_srl:    value = a >> shamt;
            alu_sra:    value = $unsigned($signed(a) >>> shamt);
            alu_or:     value = a | b;
            alu_and:    value = a & b;
            alu_pass_b: value = b;
            // jal return address
            alu_link:   value = issue.pc + 32'd4;
            default:    value = '0;
        endcase
    end

    // no-op issues still retire, rd_we is already low for them
    assign alu_valid     = issue_valid && issue.unit != unit_mul;
    assign alu_res.pc    = issue.pc;
    assign alu_res.inst  = issue.inst;
    assign alu_res.rd    = issue.rd;
    assign alu_res.rd_we = issue.rd_we;
    assign alu_res.value = value;

endmodule

// File: src/decode_unit.sv
`timescale 1ns/1ns

module decode_unit (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      fetch_valid,
    input  logic [rv32_pkg::xlen-1:0] fetch_pc,
    input  logic [31:0]               fetch_inst,
    input  logic                      mul_busy,
    input  rv32_pkg::result_t         alu_res,
    input  logic                      alu_valid,
    input  logic [rv32_pkg::xlen-1:0] rs1_data,
    input  logic [rv32_pkg::xlen-1:0] rs2_data,
    output logic                      decode_ready,
    output rv32_pkg::reg_addr_t       rs1_addr,
    output rv32_pkg::reg_addr_t       rs2_addr,
    output logic                      redirect,
    output logic [rv32_pkg::xlen-1:0] redirect_pc,
    output rv32_pkg::issue_t          issue,
    output logic                      issue_valid
);
    import rv32_pkg::*;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_u;
    logic            alt_ok;
    unit_t           unit;
    alu_op_t         alu_op;
    logic            fwd1;
    logic            fwd2;
    logic [xlen-1:0] src1;
    logic [xlen-1:0] src2;
    logic            accept;

    assign opcode   = fetch_inst[6:0];
    assign funct3   = fetch_inst[14:12];
    assign funct7   = fetch_inst[31:25];
    assign rs1_addr = fetch_inst[19:15];
    assign rs2_addr = fetch_inst[24:20];
    assign imm_i    = {{20{fetch_inst[31]}}, fetch_inst[31:20]};
    assign imm_u    = {fetch_inst[31:12], 12'b0};

    // funct7 0100000 only legal for sub and sra/srai
    assign alt_ok = funct7 == 7'b0000000 || (funct7 == 7'b0100000
        && (funct3 == 3'b101 || (opcode == opc_op && funct3 == 3'b000)));

    always_comb
    begin
        unit = unit_alu;
        case (funct3)
            3'b000:  alu_op = (opcode == opc_op && funct7[5]) ? alu_sub : alu_add;
            3'b001:  alu_op = alu_sll;
            3'b010:  alu_op = alu_slt;
            3'b011:  alu_op = alu_sltu;
            3'b100:  alu_op = alu_xor;
            3'b101:  alu_op = funct7[5] ? alu_sra : alu_srl;
            3'b110:  alu_op = alu_or;
            default: alu_op = alu_and;
        endcase
        case (opcode)
            opc_op:
                // mul low half only, other m-extension ops fall to no-op
                if (funct7 == 7'b0000001)
                    unit = (funct3 == 3'b000) ? unit_mul : unit_none;
                else if (!alt_ok)
                    unit = unit_none;
            opc_op_imm:
                if ((funct3 == 3'b001 || funct3 == 3'b101) && !alt_ok)
                    unit = unit_none;
            opc_lui: alu_op = alu_pass_b;
            opc_jal: alu_op = alu_link;
            default: unit = unit_none;
        endcase
    end

    // bypass the result still sitting in execute
    assign fwd1 = alu_valid && alu_res.rd_we && alu_res.rd != '0 && alu_res.rd == rs1_addr;
    assign fwd2 = alu_valid && alu_res.rd_we && alu_res.rd != '0 && alu_res.rd == rs2_addr;
    assign src1 = fwd1 ? alu_res.value : rs1_data;
    assign src2 = fwd2 ? alu_res.value : rs2_data;

    // hold while a multiply is pending or the jal shadow is flushed
    assign decode_ready = !(mul_busy || (issue_valid && issue.unit == unit_mul) || redirect);
    assign accept = fetch_valid && decode_ready;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            issue_valid <= 1'b0;
            redirect    <= 1'b0;
        end
        else
        begin
            issue_valid <= accept;
            // pulse while the jal sits in the issue register
            redirect    <= accept && opcode == opc_jal;
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            issue.pc        <= fetch_pc;
            issue.inst      <= fetch_inst;
            issue.rd        <= fetch_inst[11:7];
            issue.rd_we     <= unit != unit_none;
            issue.unit      <= unit;
            issue.alu_op    <= alu_op;
            issue.operand_a <= src1;
            issue.operand_b <= (opcode == opc_op) ? src2 : (opcode == opc_lui) ? imm_u : imm_i;
            redirect_pc     <= fetch_pc + jal_offset(fetch_inst);
        end
    end

    assert property (@(posedge clk) disable iff (rst) redirect |=> !redirect)
        else $error("redirect held for two cycles");

endmodule

// File: src/fetch_unit.sv
`timescale 1ns/1ns

module fetch_unit (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      imem_ack,
    input  logic [rv32_pkg::xlen-1:0] imem_rdata,
    input  logic                      decode_ready,
    input  logic                      redirect,
    input  logic [rv32_pkg::xlen-1:0] redirect_pc,
    output logic                      imem_req,
    output logic [rv32_pkg::xlen-1:0] imem_addr,
    output logic                      fetch_valid,
    output logic [rv32_pkg::xlen-1:0] fetch_pc,
    output logic [31:0]               fetch_inst
);
    import rv32_pkg::*;

    typedef enum logic [1:0] {st_idle, st_wait_ack, st_wait_release} fetch_state_t;

    fetch_state_t    state;
    // next address to fetch
    logic [xlen-1:0] pc;
    // open handshake belongs to a squashed path
    logic            discard;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state       <= st_idle;
            pc          <= '0;
            imem_req    <= 1'b0;
            fetch_valid <= 1'b0;
            discard     <= 1'b0;
        end
        else
        begin
            // buffered word taken by decode
            if (fetch_valid && decode_ready)
                fetch_valid <= 1'b0;
            case (state)
                st_idle:
                    // only with an empty buffer and ack already released
                    if (!fetch_valid && !imem_ack && !redirect)
                    begin
                        imem_req <= 1'b1;
                        state    <= st_wait_ack;
                    end
                st_wait_ack:
                    if (imem_ack)
                    begin
                        imem_req <= 1'b0;
                        state    <= st_wait_release;
                        if (!discard && !redirect)
                        begin
                            fetch_valid <= 1'b1;
                            pc          <= pc + 32'd4;
                        end
                    end
                st_wait_release:
                    // memory drops ack, phase four
                    if (!imem_ack)
                    begin
                        state   <= st_idle;
                        discard <= 1'b0;
                    end
                default:
                    state <= st_idle;
            endcase
            // redirect empties the buffer and retargets the pc
            if (redirect)
            begin
                fetch_valid <= 1'b0;
                pc          <= redirect_pc;
                if (state == st_wait_ack && !imem_ack)
                    discard <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        // address frozen once req is up
        if (state == st_idle)
            imem_addr <= pc;
        if (state == st_wait_ack && imem_ack)
        begin
            fetch_pc   <= imem_addr;
            fetch_inst <= imem_rdata;
        end
    end

    // four-phase rule on the instruction port
    assert property (@(posedge clk) disable iff (rst)
        $rose(imem_req) |-> !$past(imem_ack))
        else $error("imem_req rose while imem_ack still high");
    assert property (@(posedge clk) disable iff (rst)
        imem_req && $past(imem_req) |-> $stable(imem_addr))
        else $error("imem_addr changed during an open request");

endmodule

// File: src/rv32_pkg.sv
package rv32_pkg;

    // data path width
    localparam int xlen = 32;

    // shift-add iterations per multiply, and the counter width that covers them
    localparam int mul_cycles = 32;
    localparam int mul_cnt_w = $clog2(mul_cycles + 1);

    // major opcodes this core decodes
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_jal    = 7'b1101111;

    typedef logic [4:0] reg_addr_t;

    // pass_b carries the lui immediate, link yields pc + 4
    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
        alu_srl, alu_sra, alu_or, alu_and, alu_pass_b, alu_link
    } alu_op_t;

    // execution resource of an issued instruction
    typedef enum logic [1:0] {
        unit_none,
        unit_alu,
        unit_mul
    } unit_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [31:0]     inst;
        reg_addr_t       rd;
        logic            rd_we;
        unit_t           unit;
        alu_op_t         alu_op;
        logic [xlen-1:0] operand_a;
        logic [xlen-1:0] operand_b;
    } issue_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [31:0]     inst;
        reg_addr_t       rd;
        logic            rd_we;
        logic [xlen-1:0] value;
    } result_t;

    // one retired instruction, monitor style
    typedef struct packed {
        logic [63:0]     order;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] next_pc;
        logic [31:0]     inst;
        reg_addr_t       rd;
        logic [xlen-1:0] rd_wdata;
    } commit_t;

    // jal immediate, sign extended
    function automatic logic [xlen-1:0] jal_offset(input logic [31:0] inst);
        return {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    endfunction

endpackage
